// ==== all.f ====
+incdir+hw
hw/nabp_pkg.sv
hw/swap_state_control.sv
hw/shift_sequencer.sv
hw/s_mapper.sv
hw/line_buffer.sv
hw/nabp_processing_swappable.sv
dv/nabp_checker.sv
dv/nabp_tb.sv

// ==== dv/nabp_cases.txt ====
# name  shift_len(dec)  mp_accu_base(hex)  accu_init seg0 seg1(hex)  ack_delay(dec)
# accumulators hold 8 integer bits over 6 fraction bits
short_shift    2  0050  0000  0a00  0
equal_taps     4  0040  1000  2020  3
long_shift     9  0023  0100  3f00  1
wrap_negative  6  3fa0  0080  0040  5
single_step    1  0100  3fc0  2000  2
full_width    20  1234  0fff  3ffe  4

// ==== dv/nabp_checker.sv ====
module nabp_checker
(
    input logic clk,
    input logic reset_n,
    input logic next_itr,
    input logic swap,
    input logic pe_kick,
    input logic lb_shift,
    input logic mp_step
);

    int violations = 0;

    // the stage asks for a new iteration or for a swap, never both
    a_itr_swap: assert property (@(posedge clk) disable iff (reset_n) !(next_itr && swap))
    else
    begin
        $error("next_itr and swap high in the same cycle");
        violations++;
    end

    a_pe_kick_pulse: assert property (@(posedge clk) disable iff (reset_n) pe_kick |=> !pe_kick)
    else
    begin
        $error("pe_kick held for more than one cycle");
        violations++;
    end

    // ready and fill-done are the idle states
    a_strobe_idle: assert property (@(posedge clk) disable iff (reset_n)
        (next_itr || swap) |-> !(lb_shift || mp_step))
    else
    begin
        $error("strobe active outside fill and shift");
        violations++;
    end

endmodule

// ==== dv/nabp_tb.sv ====
`include "nabp_defines.svh"

module nabp_tb;

    typedef struct packed {
        nabp_pkg::shift_len_t shift_len;
        nabp_pkg::map_accu_t  base;
        nabp_pkg::seg_init_t  init;
        logic [7:0]           ack_delay;
    } test_case_t;

    logic                                       clk = 1'b0;
    logic                                       reset_n;
    nabp_pkg::swap_cfg_t                        cfg;
    nabp_pkg::seg_init_t                        accu_init;
    logic                                       next_itr_ack;
    logic                                       swap_ack;
    nabp_pkg::filtered_t [`NABP_NO_OF_SEGS-1:0] fr_val;
    logic                                       next_itr;
    logic                                       swap;
    logic                                       pe_kick;
    nabp_pkg::s_val_t [`NABP_NO_OF_SEGS-1:0]    s_val;
    nabp_pkg::taps_t [`NABP_NO_OF_SEGS-1:0]     taps;

    // reference model
    nabp_pkg::taps_t [`NABP_NO_OF_SEGS-1:0]     model_taps;
    nabp_pkg::s_val_t [`NABP_NO_OF_SEGS-1:0]    model_s;
    nabp_pkg::filtered_t [`NABP_NO_OF_SEGS-1:0] fr_model;

    test_case_t  case_list[$];
    string       name_list[$];
    test_case_t  cur;
    string       test_name;
    int          step_idx;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [31:0] lfsr = 32'hed27aaaa;

    always #10 clk = ~clk;

    nabp_processing_swappable dut (.*);

    bind nabp_processing_swappable nabp_checker u_checker (.*);

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_s(input string what, input nabp_pkg::s_val_t exp,
                           input nabp_pkg::s_val_t act);
        if (exp !== act)
            abort_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                                test_name, what, exp, act));
    endtask

    task automatic check_taps(input string what, input nabp_pkg::taps_t exp,
                              input nabp_pkg::taps_t act);
        if (exp !== act)
            abort_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                                test_name, what, exp, act));
    endtask

    task automatic check_level(input string what, input logic exp, input logic act);
        if (exp !== act)
            abort_run($sformatf("CHECK FAILED %s %s: expected %b, actual %b",
                                test_name, what, exp, act));
    endtask

    task automatic expect_handshake(input logic e_itr, input logic e_swap, input logic e_pe);
        check_level("next_itr", e_itr, next_itr);
        check_level("swap", e_swap, swap);
        check_level("pe_kick", e_pe, pe_kick);
    endtask

    // fibonacci lfsr x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic nabp_pkg::filtered_t random_sample();
        nabp_pkg::filtered_t v;
        logic                fb;
        for (int i = 0; i < `NABP_DATA_LENGTH; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v[i] = fb;
        end
        return v;
    endfunction

    // integer part of init + k * base, modulo the accumulator width
    function automatic nabp_pkg::s_val_t s_expected(input nabp_pkg::map_accu_t init,
                                                    input nabp_pkg::map_accu_t base, input int k);
        nabp_pkg::map_accu_t pos;
        pos = nabp_pkg::map_accu_t'(init + k * base);
        return pos[`NABP_S_LENGTH+`NABP_ACCU_FRAC-1:`NABP_ACCU_FRAC];
    endfunction

    // one clock, shift_exp marks an edge where the stage should step
    task automatic run_cycle(input logic shift_exp, input logic itr_ack, input logic sw_ack);
        nabp_pkg::filtered_t [`NABP_NO_OF_SEGS-1:0] fresh;
        @(posedge clk);
        for (int seg = 0; seg < `NABP_NO_OF_SEGS; seg++)
        begin
            if (shift_exp)
            begin
                model_taps[seg] = {model_taps[seg][`NABP_NO_OF_TAPS-2:0], fr_model[seg]};
                model_s[seg]    = s_expected(cur.init[seg], cur.base, step_idx);
            end
            fresh[seg] = random_sample();
        end
        step_idx += shift_exp;
        fr_model = fresh;
        fr_val       <= fresh;
        if (itr_ack)
        begin
            cfg       <= '{shift_len: cur.shift_len, mp_accu_base: cur.base};
            accu_init <= cur.init;
        end
        else
        begin
            // only the values seen on the ack edge may reach the iteration
            cfg       <= ~{cur.shift_len, cur.base};
            accu_init <= ~cur.init;
        end
        next_itr_ack <= itr_ack;
        swap_ack     <= sw_ack;
        cycle_count++;
        if (cycle_count > cycle_limit)
            abort_run("timeout: the stage did not finish within the cycle limit");
        @(negedge clk);
        for (int seg = 0; seg < `NABP_NO_OF_SEGS; seg++)
        begin
            check_taps($sformatf("taps[%0d]", seg), model_taps[seg], taps[seg]);
            check_s($sformatf("s_val[%0d]", seg), model_s[seg], s_val[seg]);
        end
    endtask

    task automatic run_case(input int idx);
        test_name = name_list[idx];
        cur       = case_list[idx];
        step_idx  = 0;
        while (next_itr !== 1'b1)
            run_cycle(1'b0, 1'b0, 1'b0);
        // ack edge, still ready until the next edge
        run_cycle(1'b0, 1'b1, 1'b0);
        expect_handshake(1'b1, 1'b0, 1'b0);
        run_cycle(1'b0, 1'b0, 1'b0);
        expect_handshake(1'b0, 1'b0, 1'b0);
        for (int i = 0; i < `NABP_NO_OF_TAPS; i++)
        begin
            run_cycle(1'b1, 1'b0, 1'b0);
            expect_handshake(1'b0, i == `NABP_NO_OF_TAPS - 1, 1'b0);
        end
        // back-pressure, taps must hold
        for (int i = 0; i < cur.ack_delay; i++)
        begin
            run_cycle(1'b0, 1'b0, 1'b0);
            expect_handshake(1'b0, 1'b1, 1'b0);
        end
        run_cycle(1'b0, 1'b0, 1'b1);
        expect_handshake(1'b0, 1'b1, 1'b0);
        run_cycle(1'b0, 1'b0, 1'b0);
        expect_handshake(1'b0, 1'b0, 1'b1);
        for (int i = 0; i < cur.shift_len; i++)
        begin
            run_cycle(1'b1, 1'b0, 1'b0);
            expect_handshake(i == cur.shift_len - 1, 1'b0, 1'b0);
        end
    endtask

    initial
    begin
        int                   fd;
        int                   n;
        string                line;
        string                nm;
        nabp_pkg::shift_len_t len_v;
        logic [7:0]           dly_v;
        nabp_pkg::map_accu_t  base_v;
        nabp_pkg::map_accu_t  init0_v;
        nabp_pkg::map_accu_t  init1_v;
        reset_n      = 1'b1;
        cfg          = '0;
        accu_init    = '0;
        next_itr_ack = 1'b0;
        swap_ack     = 1'b0;
        fr_val       = '0;
        model_taps   = '0;
        model_s      = '0;
        fr_model     = '0;
        cur          = '0;
        fd = $fopen("dv/nabp_cases.txt", "r");
        if (fd == 0)
            abort_run("could not open dv/nabp_cases.txt");
        while (!$feof(fd))
        begin
            line = "";
            n    = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%s %d %h %h %h %d", nm, len_v, base_v, init0_v, init1_v, dly_v);
                if (n != 6)
                    abort_run({"malformed line in case file: ", line});
                name_list.push_back(nm);
                case_list.push_back('{shift_len: len_v, base: base_v,
                                      init: {init1_v, init0_v}, ack_delay: dly_v});
                cycle_limit += `NABP_NO_OF_TAPS + len_v + dly_v + 20;
            end
        end
        $fclose(fd);
        if (case_list.size() == 0)
            abort_run("case file holds no test cases");
        repeat (8) @(posedge clk);
        reset_n <= 1'b0;
        @(negedge clk);
        test_name = "reset";
        expect_handshake(1'b1, 1'b0, 1'b0);
        for (int seg = 0; seg < `NABP_NO_OF_SEGS; seg++)
        begin
            check_taps($sformatf("taps[%0d]", seg), '0, taps[seg]);
            check_s($sformatf("s_val[%0d]", seg), '0, s_val[seg]);
        end
        for (int i = 0; i < case_list.size(); i++)
            run_case(i);
        if (dut.u_checker.violations != 0)
            abort_run("the bound checker reported assertion failures");
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// ==== hw/line_buffer.sv ====
`include "nabp_defines.svh"

module line_buffer
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 shift,
    input  nabp_pkg::filtered_t  shift_in,
    output nabp_pkg::taps_t      taps
);

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            taps <= '0;
        end
        else if (shift)
        begin
            // newest sample at tap 0, oldest drops off the top
            taps <= {taps[`NABP_NO_OF_TAPS-2:0], shift_in};
        end
    end

endmodule

// ==== hw/nabp_defines.svh ====
`ifndef NABP_DEFINES_SVH
`define NABP_DEFINES_SVH

// line/segment divisions of the stage
`define NABP_NO_OF_SEGS 2

// taps per line buffer, also the fill length
`define NABP_NO_OF_TAPS 4

// filtered sample width
`define NABP_DATA_LENGTH 12

// s address width toward the filtered RAM
`define NABP_S_LENGTH 8

// fractional bits kept in the mapper accumulator
`define NABP_ACCU_FRAC 6

// width of the programmed shift-phase length
`define NABP_SHIFT_CNT_LENGTH 6

`endif

// ==== hw/nabp_pkg.sv ====
`include "nabp_defines.svh"

package nabp_pkg;

    // one filtered sample
    typedef logic signed [`NABP_DATA_LENGTH-1:0] filtered_t;

    // s address into the filtered RAM
    typedef logic [`NABP_S_LENGTH-1:0] s_val_t;

    // integer part on top, fraction below
    typedef logic [`NABP_S_LENGTH+`NABP_ACCU_FRAC-1:0] map_accu_t;

    typedef logic [`NABP_SHIFT_CNT_LENGTH-1:0] shift_len_t;

    // tap 0 holds the newest sample
    typedef filtered_t [`NABP_NO_OF_TAPS-1:0] taps_t;

    // per-iteration configuration from the outside swap control
    typedef struct packed {
        shift_len_t shift_len;
        map_accu_t  mp_accu_base;
    } swap_cfg_t;

    // one initial accumulator per segment
    typedef map_accu_t [`NABP_NO_OF_SEGS-1:0] seg_init_t;

endpackage

// ==== hw/nabp_processing_swappable.sv ====
`include "nabp_defines.svh"

module nabp_processing_swappable
(
    input  logic                                        clk,
    input  logic                                        reset_n,
    input  nabp_pkg::swap_cfg_t                         cfg,
    input  nabp_pkg::seg_init_t                         accu_init,
    input  logic                                        next_itr_ack,
    input  logic                                        swap_ack,
    input  nabp_pkg::filtered_t [`NABP_NO_OF_SEGS-1:0]  fr_val,
    output logic                                        next_itr,
    output logic                                        swap,
    output logic                                        pe_kick,
    output nabp_pkg::s_val_t [`NABP_NO_OF_SEGS-1:0]     s_val,
    output nabp_pkg::taps_t [`NABP_NO_OF_SEGS-1:0]      taps
);

    // controller to sequencer
    logic                 fill_kick;
    logic                 shift_kick;
    nabp_pkg::shift_len_t shift_len;
    nabp_pkg::map_accu_t  mp_accu_base;

    // sequencer answers and strobes
    logic fill_done;
    logic shift_done;
    logic mp_kick;
    logic mp_step;
    logic lb_shift;

    swap_state_control u_state_control
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .cfg          (cfg),
        .next_itr_ack (next_itr_ack),
        .swap_ack     (swap_ack),
        .fill_done    (fill_done),
        .shift_done   (shift_done),
        .next_itr     (next_itr),
        .swap         (swap),
        .fill_kick    (fill_kick),
        .shift_kick   (shift_kick),
        .shift_len    (shift_len),
        .mp_accu_base (mp_accu_base)
    );

    shift_sequencer u_sequencer
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .fill_kick  (fill_kick),
        .shift_kick (shift_kick),
        .shift_len  (shift_len),
        .fill_done  (fill_done),
        .shift_done (shift_done),
        .mp_kick    (mp_kick),
        .mp_step    (mp_step),
        .lb_shift   (lb_shift),
        .pe_kick    (pe_kick)
    );

    // one mapper and one line buffer per segment, all on shared strobes
    for (genvar seg = 0; seg < `NABP_NO_OF_SEGS; seg++)
    begin : g_seg
        s_mapper u_mapper
        (
            .clk       (clk),
            .reset_n   (reset_n),
            .accu_init (accu_init[seg]),
            .accu_base (mp_accu_base),
            .kick      (mp_kick),
            .step      (mp_step),
            .s_val     (s_val[seg])
        );

        line_buffer u_line_buffer
        (
            .clk      (clk),
            .reset_n  (reset_n),
            .shift    (lb_shift),
            .shift_in (fr_val[seg]),
            .taps     (taps[seg])
        );
    end

endmodule

// ==== hw/s_mapper.sv ====
`include "nabp_defines.svh"

module s_mapper
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  nabp_pkg::map_accu_t   accu_init,
    input  nabp_pkg::map_accu_t   accu_base,
    input  logic                  kick,
    input  logic                  step,
    output nabp_pkg::s_val_t      s_val
);

    nabp_pkg::map_accu_t accu;

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            accu  <= '0;
            s_val <= '0;
        end
        else if (kick)
        begin
            accu <= accu_init;
        end
        else if (step)
        begin
            // emit the current position, then advance
            s_val <= accu[`NABP_S_LENGTH+`NABP_ACCU_FRAC-1:`NABP_ACCU_FRAC];
            // wraps modulo the accumulator width
            accu  <= accu + accu_base;
        end
    end

endmodule

// ==== hw/shift_sequencer.sv ====
`include "nabp_defines.svh"

module shift_sequencer
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   fill_kick,
    input  logic                   shift_kick,
    input  nabp_pkg::shift_len_t   shift_len,
    output logic                   fill_done,
    output logic                   shift_done,
    output logic                   mp_kick,
    output logic                   mp_step,
    output logic                   lb_shift,
    output logic                   pe_kick
);

    // remaining steps in the current phase, zero when idle
    nabp_pkg::shift_len_t cnt;
    logic                 in_shift;
    logic                 active;
    logic                 last;

    assign active = (cnt != '0);
    assign last   = (cnt == nabp_pkg::shift_len_t'(1));

    // a shift_len of zero would never finish, the outside control avoids it
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            cnt      <= '0;
            in_shift <= 1'b0;
            pe_kick  <= 1'b0;
        end
        else
        begin
            pe_kick <= shift_kick;
            if (fill_kick)
            begin
                cnt      <= nabp_pkg::shift_len_t'(`NABP_NO_OF_TAPS);
                in_shift <= 1'b0;
            end
            else if (shift_kick)
            begin
                cnt      <= shift_len;
                in_shift <= 1'b1;
            end
            else if (active)
            begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // mappers load their start value on the same edge the fill begins
    assign mp_kick = fill_kick;

    // mappers and line buffers advance together
    assign mp_step  = active;
    assign lb_shift = active;

    assign fill_done  = last && !in_shift;
    assign shift_done = last && in_shift;

endmodule

// ==== hw/swap_state_control.sv ====
module swap_state_control
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  nabp_pkg::swap_cfg_t    cfg,
    input  logic                   next_itr_ack,
    input  logic                   swap_ack,
    input  logic                   fill_done,
    input  logic                   shift_done,
    output logic                   next_itr,
    output logic                   swap,
    output logic                   fill_kick,
    output logic                   shift_kick,
    output nabp_pkg::shift_len_t   shift_len,
    output nabp_pkg::map_accu_t    mp_accu_base
);

    typedef enum logic [1:0] {
        READY     = 2'd0,
        FILL      = 2'd1,
        FILL_DONE = 2'd2,
        SHIFT     = 2'd3
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state <= READY;
        end
        else
        begin
            state <= next_state;
        end
    end

    // config is taken while idle, so the next one may be staged mid-iteration
    always_ff @(posedge clk)
    begin
        if (state == READY)
        begin
            shift_len    <= cfg.shift_len;
            mp_accu_base <= cfg.mp_accu_base;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            READY:
            begin
                if (next_itr_ack)
                begin
                    next_state = FILL;
                end
            end
            FILL:
            begin
                if (fill_done)
                begin
                    next_state = FILL_DONE;
                end
            end
            FILL_DONE:
            begin
                if (swap_ack)
                begin
                    next_state = SHIFT;
                end
            end
            SHIFT:
            begin
                if (shift_done)
                begin
                    next_state = READY;
                end
            end
            default:
            begin
                next_state = READY;
            end
        endcase
    end

    // request a new iteration only once out of reset
    assign next_itr = !reset_n && (state == READY);
    assign swap     = (state == FILL_DONE);

    // kicks fire on the transition edge into the phase
    assign fill_kick  = (state != FILL) && (next_state == FILL);
    assign shift_kick = (state != SHIFT) && (next_state == SHIFT);

endmodule
